//--- design/usb_rx_cfg.svh
// usb rx configuration: bit timing and crc constants for the receiver.
`ifndef USB_RX_CFG_SVH
`define USB_RX_CFG_SVH

// full speed line sampled at 48 MHz.
`define USB_RX_CLKS_PER_BIT 4

// clocks after a resynchronizing edge before the line is sampled.
`define USB_RX_SAMPLE_PHASE 2

// x^5 + x^2 + 1, remainder left by a good token.
`define USB_RX_CRC5_POLY 5'h05
`define USB_RX_CRC5_RESIDUE 5'h0c

// x^16 + x^15 + x^2 + 1, remainder left by a good data packet.
`define USB_RX_CRC16_POLY 16'h8005
`define USB_RX_CRC16_RESIDUE 16'h800d

`endif

//--- design/usb_rx_pkg.sv
// usb rx package: bit slot struct, packet codes and pid values.
`default_nettype none

package usb_rx_pkg;

  // one decoded bit slot on the line.
  typedef struct packed {
    logic valid;
    logic value;
    logic eop;
  } rx_bit_t;

  typedef enum logic [2:0] {
    RX_NONE,
    RX_TOKEN_IN,
    RX_TOKEN_OUT,
    RX_TOKEN_SETUP,
    RX_DATA,
    RX_ACK,
    RX_NAK,
    RX_ERROR
  } rx_packet_e;

  // low nibble of the pid byte.
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010
  } pid_e;

endpackage

`default_nettype wire

//--- design/usb_rx_sampler.sv
// usb rx sampler: recovers bit timing, decodes nrzi and flags se0 as eop.
`default_nettype none
`include "usb_rx_cfg.svh"

module usb_rx_sampler (
  input  logic                clk,
  input  logic                n_rst,
  input  logic                d_plus,
  input  logic                d_minus,
  output usb_rx_pkg::rx_bit_t raw_bit
);

  localparam int CNT_W = $clog2(`USB_RX_CLKS_PER_BIT);

  logic [1:0]       dp_sync;
  logic [1:0]       dm_sync;
  logic [1:0]       line;
  logic [1:0]       line_prev;
  logic [CNT_W-1:0] phase;
  logic             last_level;
  logic             active;
  logic             line_edge;
  logic             se0;
  logic             sample;

  assign line      = {dp_sync[1], dm_sync[1]};
  assign line_edge = (line != line_prev);
  assign se0       = (line == 2'b00);
  assign sample    = active && !line_edge && (phase == CNT_W'(`USB_RX_SAMPLE_PHASE));

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      dp_sync    <= 2'b11;
      dm_sync    <= 2'b00;
      line_prev  <= 2'b10;
      phase      <= '0;
      last_level <= 1'b1;
      active     <= 1'b0;
      raw_bit    <= '0;
    end else begin
      dp_sync   <= {dp_sync[0], d_plus};
      dm_sync   <= {dm_sync[0], d_minus};
      line_prev <= line;
      // every transition restarts the bit clock.
      if (line_edge) begin
        phase <= CNT_W'(1);
      end else if (phase == CNT_W'(`USB_RX_CLKS_PER_BIT - 1)) begin
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
      // first k after idle j opens the packet.
      if (!active && line == 2'b01) begin
        active <= 1'b1;
      end else if (sample && se0) begin
        active <= 1'b0;
      end
      if (sample) begin
        last_level <= se0 ? 1'b1 : line[1];
      end
      raw_bit <= '{valid: sample, value: !se0 && (line[1] == last_level), eop: se0};
    end
  end

endmodule

`default_nettype wire

//--- design/usb_rx_destuff.sv
// usb rx destuffer: drops stuffed zeros and flags stuffing violations.
`default_nettype none

module usb_rx_destuff (
  input  logic                clk,
  input  logic                n_rst,
  input  usb_rx_pkg::rx_bit_t raw_bit,
  output usb_rx_pkg::rx_bit_t data_bit,
  output logic                stuff_error
);

  logic [2:0] ones;
  logic       stuffed;

  // the slot after six ones carries no data.
  assign stuffed = raw_bit.valid && !raw_bit.eop && (ones == 3'd6);

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      ones        <= '0;
      data_bit    <= '0;
      stuff_error <= 1'b0;
    end else begin
      data_bit    <= '{valid: raw_bit.valid && !stuffed, value: raw_bit.value,
                       eop: raw_bit.eop};
      stuff_error <= stuffed && raw_bit.value;
      if (raw_bit.valid) begin
        if (raw_bit.eop || stuffed || !raw_bit.value) begin
          ones <= '0;
        end else begin
          ones <= ones + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/usb_rx_crc.sv
// usb rx crc checker: serial lfsr over the bits after the pid.
`default_nettype none
`include "usb_rx_cfg.svh"

module usb_rx_crc #(
  parameter int               WIDTH   = 5,
  parameter logic [WIDTH-1:0] POLY    = `USB_RX_CRC5_POLY,
  parameter logic [WIDTH-1:0] RESIDUE = `USB_RX_CRC5_RESIDUE
) (
  input  logic                clk,
  input  logic                n_rst,
  input  logic                clear,
  input  usb_rx_pkg::rx_bit_t data_bit,
  output logic                pass
);

  logic [WIDTH-1:0] crc;
  logic             feedback;

  assign feedback = crc[WIDTH-1] ^ data_bit.value;

  // good packets leave a fixed remainder.
  assign pass = (crc == RESIDUE);

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      crc <= '1;
    end else if (clear) begin
      crc <= '1;
    end else if (data_bit.valid && !data_bit.eop) begin
      crc <= {crc[WIDTH-2:0], 1'b0} ^ (feedback ? POLY : '0);
    end
  end

endmodule

`default_nettype wire

//--- design/usb_rx_deser.sv
// usb rx deserializer: shifts bits into a three byte window and marks byte ends.
`default_nettype none

module usb_rx_deser (
  input  logic                clk,
  input  logic                n_rst,
  input  logic                clear,
  input  usb_rx_pkg::rx_bit_t data_bit,
  output logic [23:0]         shift_word,
  output logic                byte_done
);

  logic [2:0] bit_cnt;
  logic       shift;

  assign shift = data_bit.valid && !data_bit.eop;

  // lsb arrives first, so the newest byte settles in the top lane.
  always_ff @(posedge clk) begin
    if (shift) begin
      shift_word <= {data_bit.value, shift_word[23:1]};
    end
  end

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      bit_cnt   <= '0;
      byte_done <= 1'b0;
    end else begin
      byte_done <= shift && (bit_cnt == 3'd7);
      if (clear) begin
        bit_cnt <= '0;
      end else if (shift) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/usb_rx_ctrl.sv
// usb rx controller: tracks sync, pid and payload and reports the packet kind.
`default_nettype none

module usb_rx_ctrl (
  input  logic                   clk,
  input  logic                   n_rst,
  input  usb_rx_pkg::rx_bit_t    data_bit,
  input  logic                   stuff_error,
  input  logic                   byte_done,
  input  logic [23:0]            shift_word,
  input  logic                   crc5_pass,
  input  logic                   crc16_pass,
  output logic                   crc_clear,
  output logic                   deser_clear,
  output logic                   store_data,
  output logic [7:0]             packet_data,
  output usb_rx_pkg::rx_packet_e rx_packet
);

  import usb_rx_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SYNC,
    ST_PID,
    ST_TOKEN,
    ST_DATA,
    ST_HANDSHAKE,
    ST_DONE
  } state_e;

  state_e     state;
  state_e     pid_next;
  rx_packet_e pid_kind;
  rx_packet_e kind;
  rx_packet_e final_code;
  logic [2:0] zeros;
  logic [1:0] byte_cnt;
  logic       err;
  logic       aligned;
  logic       bad;
  logic       bit_in;

  assign bit_in = data_bit.valid && !data_bit.eop;

  // last two bytes are the crc and never leave.
  assign store_data  = byte_done && (state == ST_DATA) && (byte_cnt >= 2'd2);
  assign packet_data = shift_word[7:0];

  always_comb begin
    pid_next = ST_DONE;
    pid_kind = RX_ERROR;
    if (shift_word[19:16] == ~shift_word[23:20]) begin
      case (shift_word[19:16])
        PID_IN:    begin pid_next = ST_TOKEN;     pid_kind = RX_TOKEN_IN;    end
        PID_OUT:   begin pid_next = ST_TOKEN;     pid_kind = RX_TOKEN_OUT;   end
        PID_SETUP: begin pid_next = ST_TOKEN;     pid_kind = RX_TOKEN_SETUP; end
        PID_DATA0: begin pid_next = ST_DATA;      pid_kind = RX_DATA;        end
        PID_DATA1: begin pid_next = ST_DATA;      pid_kind = RX_DATA;        end
        PID_ACK:   begin pid_next = ST_HANDSHAKE; pid_kind = RX_ACK;         end
        PID_NAK:   begin pid_next = ST_HANDSHAKE; pid_kind = RX_NAK;         end
        default:   begin pid_next = ST_DONE;      pid_kind = RX_ERROR;       end
      endcase
    end
  end

  // verdict taken when the eop slot arrives.
  always_comb begin
    bad = err || !aligned;
    case (state)
      ST_TOKEN:     bad = bad || (byte_cnt != 2'd2) || !crc5_pass;
      ST_DATA:      bad = bad || (byte_cnt < 2'd2) || !crc16_pass;
      ST_HANDSHAKE: bad = bad || (byte_cnt != 2'd0);
      default:      bad = 1'b1;
    endcase
    final_code = bad ? RX_ERROR : kind;
  end

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      state       <= ST_IDLE;
      kind        <= RX_NONE;
      zeros       <= '0;
      byte_cnt    <= '0;
      err         <= 1'b0;
      aligned     <= 1'b0;
      rx_packet   <= RX_NONE;
      crc_clear   <= 1'b1;
      deser_clear <= 1'b1;
    end else begin
      crc_clear   <= 1'b0;
      deser_clear <= 1'b0;
      if (stuff_error && state != ST_IDLE) begin
        err <= 1'b1;
      end
      if (byte_done) begin
        aligned <= 1'b1;
      end else if (bit_in) begin
        aligned <= 1'b0;
      end
      if (data_bit.valid && data_bit.eop && state != ST_IDLE) begin
        rx_packet <= final_code;
        state     <= ST_IDLE;
      end else begin
        case (state)
          ST_IDLE: begin
            if (bit_in && !data_bit.value) begin
              state       <= ST_SYNC;
              zeros       <= 3'd1;
              err         <= 1'b0;
              rx_packet   <= RX_NONE;
              deser_clear <= 1'b1;
            end
          end
          ST_SYNC: begin
            if (bit_in && !data_bit.value && zeros != 3'd7) begin
              zeros <= zeros + 1'b1;
            end else if (bit_in && data_bit.value && zeros == 3'd7) begin
              state       <= ST_PID;
              deser_clear <= 1'b1;
            end else if (bit_in) begin
              err   <= 1'b1;
              state <= ST_DONE;
            end
          end
          ST_PID: begin
            if (byte_done) begin
              state     <= pid_next;
              kind      <= pid_kind;
              byte_cnt  <= '0;
              crc_clear <= 1'b1;
            end
          end
          ST_TOKEN, ST_DATA, ST_HANDSHAKE: begin
            if (byte_done && byte_cnt != 2'd3) begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- design/usb_rx.sv
// usb rx top: full speed receive pipeline from line pair to packet bytes.
`default_nettype none
`include "usb_rx_cfg.svh"

module usb_rx (
  input  logic                   clk,
  input  logic                   n_rst,
  input  logic                   d_plus,
  input  logic                   d_minus,
  output usb_rx_pkg::rx_packet_e rx_packet,
  output logic                   store_data,
  output logic [7:0]             packet_data
);

  import usb_rx_pkg::*;

  rx_bit_t     raw_bit;
  rx_bit_t     data_bit;
  logic        stuff_error;
  logic        crc_clear;
  logic        deser_clear;
  logic        crc5_pass;
  logic        crc16_pass;
  logic        byte_done;
  logic [23:0] shift_word;

  usb_rx_sampler u_sampler (
    .clk(clk), .n_rst(n_rst), .d_plus(d_plus), .d_minus(d_minus), .raw_bit(raw_bit)
  );

  usb_rx_destuff u_destuff (
    .clk(clk), .n_rst(n_rst), .raw_bit(raw_bit), .data_bit(data_bit),
    .stuff_error(stuff_error)
  );

  usb_rx_crc #(
    .WIDTH(5), .POLY(`USB_RX_CRC5_POLY), .RESIDUE(`USB_RX_CRC5_RESIDUE)
  ) u_crc5 (
    .clk(clk), .n_rst(n_rst), .clear(crc_clear), .data_bit(data_bit), .pass(crc5_pass)
  );

  usb_rx_crc #(
    .WIDTH(16), .POLY(`USB_RX_CRC16_POLY), .RESIDUE(`USB_RX_CRC16_RESIDUE)
  ) u_crc16 (
    .clk(clk), .n_rst(n_rst), .clear(crc_clear), .data_bit(data_bit), .pass(crc16_pass)
  );

  usb_rx_deser u_deser (
    .clk(clk), .n_rst(n_rst), .clear(deser_clear), .data_bit(data_bit),
    .shift_word(shift_word), .byte_done(byte_done)
  );

  usb_rx_ctrl u_ctrl (
    .clk(clk), .n_rst(n_rst), .data_bit(data_bit), .stuff_error(stuff_error),
    .byte_done(byte_done), .shift_word(shift_word), .crc5_pass(crc5_pass),
    .crc16_pass(crc16_pass), .crc_clear(crc_clear), .deser_clear(deser_clear),
    .store_data(store_data), .packet_data(packet_data), .rx_packet(rx_packet)
  );

endmodule

`default_nettype wire

//--- test/usb_rx_asserts.sv
// usb rx assertions: strobe spacing and the packet code out of reset.
`default_nettype none

module usb_rx_asserts (
  input logic                   clk,
  input logic                   n_rst,
  input usb_rx_pkg::rx_bit_t    raw_bit,
  input logic                   store_data,
  input usb_rx_pkg::rx_packet_e rx_packet
);

  import usb_rx_pkg::*;

  // a byte strobe lasts one clock.
  store_single: assert property (@(posedge clk) disable iff (!n_rst)
    store_data |-> !$past(store_data))
    else $error("store_data was high in two adjacent cycles");

  // bit slots come one per bit time.
  slot_spacing: assert property (@(posedge clk) disable iff (!n_rst)
    raw_bit.valid |-> !$past(raw_bit.valid) && !$past(raw_bit.valid, 2))
    else $error("raw_bit valid pulses closer than three clocks");

  reset_code: assert property (@(posedge clk) $rose(n_rst) |-> rx_packet == RX_NONE)
    else $error("rx_packet was not RX_NONE when reset was released");

endmodule

bind usb_rx usb_rx_asserts u_asserts (
  .clk(clk), .n_rst(n_rst), .raw_bit(raw_bit), .store_data(store_data),
  .rx_packet(rx_packet)
);

`default_nettype wire

//--- test/tb_usb_rx.sv
// usb rx testbench: builds line level packets and runs directed receive tests.
`default_nettype none
`include "usb_rx_cfg.svh"

module tb_usb_rx;

  import usb_rx_pkg::*;

  localparam logic [1:0] LINE_J   = 2'b10;
  localparam logic [1:0] LINE_SE0 = 2'b00;
  // usb generators, x^5 + x^2 + 1 and x^16 + x^15 + x^2 + 1.
  localparam logic [15:0] CRC5_POLY  = 16'h0005;
  localparam logic [15:0] CRC16_POLY = 16'h8005;
  // about 2200 clocks of packets, with margin.
  localparam int MAX_CYCLES = 4000;

  logic       clk;
  logic       n_rst;
  logic       d_plus;
  logic       d_minus;
  rx_packet_e rx_packet;
  logic       store_data;
  logic [7:0] packet_data;

  logic       bit_q[$];
  logic [1:0] level_q[$];
  logic [7:0] payload_q[$];
  logic [7:0] stored_q[$];
  int         cycle_cnt;

  usb_rx u_usb_rx (
    .clk(clk), .n_rst(n_rst), .d_plus(d_plus), .d_minus(d_minus),
    .rx_packet(rx_packet), .store_data(store_data), .packet_data(packet_data)
  );

  always #2 clk = ~clk;

  // every strobed byte, sampled away from the active edge.
  always @(negedge clk) begin
    if (n_rst && store_data) begin
      stored_q.push_back(packet_data);
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      report_failure($sformatf("timeout: tests still running after %0d cycles", cycle_cnt));
    end
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else
      report_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic logic [7:0] pid_with_check(input pid_e pid);
    return {~pid, pid};
  endfunction

  task automatic push_bits(input logic [15:0] value, input int count);
    for (int i = 0; i < count; i++) begin
      bit_q.push_back(value[i]);
    end
  endtask

  // sync then pid, both lsb first.
  task automatic begin_packet(input logic [7:0] pid_byte);
    bit_q.delete();
    push_bits(16'h0080, 8);
    push_bits({8'h00, pid_byte}, 8);
  endtask

  task automatic append_crc(input int width, input logic [15:0] poly);
    logic [15:0] crc;
    logic [15:0] mask;
    logic        fb;
    mask = 16'((32'd1 << width) - 1);
    crc  = mask;
    for (int i = 16; i < bit_q.size(); i++) begin
      fb  = crc[width-1] ^ bit_q[i];
      crc = ((crc << 1) ^ (fb ? poly : 16'h0000)) & mask;
    end
    crc = ~crc & mask;
    // sent inverted, high bit first.
    for (int i = width - 1; i >= 0; i--) begin
      bit_q.push_back(crc[i]);
    end
  endtask

  task automatic build_token(input pid_e pid, input bit bad_crc);
    begin_packet(pid_with_check(pid));
    push_bits(16'($urandom()), 11);
    append_crc(5, CRC5_POLY);
    if (bad_crc) begin
      bit_q[bit_q.size() - 1] = ~bit_q[bit_q.size() - 1];
    end
  endtask

  task automatic build_data(input pid_e pid, input int flip_at);
    begin_packet(pid_with_check(pid));
    foreach (payload_q[i]) begin
      push_bits({8'h00, payload_q[i]}, 8);
    end
    append_crc(16, CRC16_POLY);
    if (flip_at >= 0) begin
      bit_q[16 + flip_at] = ~bit_q[16 + flip_at];
    end
  endtask

  // stuffing, nrzi and the se0 se0 j ending.
  task automatic encode_line(input bit stuff_on);
    logic [1:0] level;
    int         ones;
    level = LINE_J;
    ones  = 0;
    level_q.delete();
    foreach (bit_q[i]) begin
      if (!bit_q[i]) begin
        level = ~level;
      end
      level_q.push_back(level);
      ones = bit_q[i] ? ones + 1 : 0;
      if (stuff_on && ones == 6) begin
        level = ~level;
        level_q.push_back(level);
        ones = 0;
      end
    end
    level_q.push_back(LINE_SE0);
    level_q.push_back(LINE_SE0);
    repeat (3) level_q.push_back(LINE_J);
  endtask

  task automatic drive_levels(input int first, input int last);
    for (int i = first; i < last; i++) begin
      @(posedge clk);
      #1;
      {d_plus, d_minus} = level_q[i];
      repeat (`USB_RX_CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic wait_code();
    int waited;
    waited = 0;
    while (rx_packet == RX_NONE && waited < 64) begin
      @(negedge clk);
      waited++;
    end
    assert (rx_packet != RX_NONE) else
      report_failure("no packet code was reported after the end of packet");
    @(negedge clk);
  endtask

  task automatic send_packet(input bit stuff_on);
    encode_line(stuff_on);
    stored_q.delete();
    drive_levels(0, level_q.size());
    wait_code();
  endtask

  task automatic check_stored();
    check_equal("stored byte count", stored_q.size(), payload_q.size());
    foreach (payload_q[i]) begin
      check_equal($sformatf("packet_data[%0d]", i), stored_q[i], payload_q[i]);
    end
  endtask

  task automatic test_idle();
    repeat (20) begin
      @(negedge clk);
      check_equal("rx_packet", rx_packet, RX_NONE);
      check_equal("store_data", store_data, 1'b0);
    end
  endtask

  task automatic test_tokens();
    pid_e pids[3];
    rx_packet_e codes[3];
    pids  = '{PID_IN, PID_OUT, PID_SETUP};
    codes = '{RX_TOKEN_IN, RX_TOKEN_OUT, RX_TOKEN_SETUP};
    for (int i = 0; i < 3; i++) begin
      build_token(pids[i], 1'b0);
      send_packet(1'b1);
      check_equal("rx_packet", rx_packet, codes[i]);
      check_equal("stored byte count", stored_q.size(), 0);
    end
  endtask

  task automatic test_data();
    payload_q.delete();
    repeat (5) payload_q.push_back(8'($urandom()));
    build_data(PID_DATA0, -1);
    send_packet(1'b1);
    check_equal("rx_packet", rx_packet, RX_DATA);
    check_stored();
    // long runs of ones need stuffed zeros.
    payload_q.delete();
    repeat (3) payload_q.push_back(8'hff);
    build_data(PID_DATA1, -1);
    send_packet(1'b1);
    check_equal("rx_packet", rx_packet, RX_DATA);
    check_stored();
  endtask

  task automatic test_handshakes();
    begin_packet(pid_with_check(PID_ACK));
    send_packet(1'b1);
    check_equal("rx_packet", rx_packet, RX_ACK);
    begin_packet(pid_with_check(PID_NAK));
    send_packet(1'b1);
    check_equal("rx_packet", rx_packet, RX_NAK);
  endtask

  task automatic test_errors();
    payload_q.delete();
    repeat (4) payload_q.push_back(8'($urandom()));
    build_data(PID_DATA0, 9);
    send_packet(1'b1);
    check_equal("rx_packet", rx_packet, RX_ERROR);
    build_token(PID_OUT, 1'b1);
    send_packet(1'b1);
    check_equal("rx_packet", rx_packet, RX_ERROR);
    begin_packet(pid_with_check(PID_ACK) ^ 8'h40);
    send_packet(1'b1);
    check_equal("rx_packet", rx_packet, RX_ERROR);
    payload_q.delete();
    repeat (2) payload_q.push_back(8'hff);
    build_data(PID_DATA0, -1);
    send_packet(1'b0);
    check_equal("rx_packet", rx_packet, RX_ERROR);
  endtask

  task automatic test_recovery();
    begin_packet(pid_with_check(PID_NAK) ^ 8'h10);
    send_packet(1'b1);
    check_equal("rx_packet", rx_packet, RX_ERROR);
    build_token(PID_OUT, 1'b0);
    encode_line(1'b1);
    // code is cleared once sync is under way.
    drive_levels(0, 12);
    @(negedge clk);
    check_equal("rx_packet", rx_packet, RX_NONE);
    drive_levels(12, level_q.size());
    wait_code();
    check_equal("rx_packet", rx_packet, RX_TOKEN_OUT);
  endtask

  initial begin
    clk       = 1'b0;
    n_rst     = 1'b0;
    d_plus    = 1'b1;
    d_minus   = 1'b0;
    cycle_cnt = 0;
    void'($urandom(32'h1aa2_6576));
    repeat (2) @(posedge clk);
    #1;
    n_rst = 1'b1;
    test_idle();
    test_tokens();
    test_data();
    test_handshakes();
    test_errors();
    test_recovery();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- usb_rx.f
+incdir+design
design/usb_rx_pkg.sv
design/usb_rx_sampler.sv
design/usb_rx_destuff.sv
design/usb_rx_crc.sv
design/usb_rx_deser.sv
design/usb_rx_ctrl.sv
design/usb_rx.sv
test/usb_rx_asserts.sv
test/tb_usb_rx.sv

//--- run.sh
#!/usr/bin/env bash
# Build the usb_rx testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_usb_rx -f usb_rx.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_usb_rx 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Everything OK"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
